// ==== ad2s1210.f ====
design/ad2s1210Pkg.sv
design/resolverRegs.sv
design/resolverSpiReader.sv
design/resolverSequencer.sv
design/ad2s1210Top.sv
tb/ad2s1210_assertions.sv
tb/ad2s1210Tb.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = ad2s1210Tb
FILELIST  = ad2s1210.f
FLAGS     = --binary --timing --assert
OBJDIR    = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== tb/ad2s1210Tb.sv ====
// ============================================================
// Testbench for the AD2S1210 controller
// Clock, reset, LFSR stimulus and host bus tasks
// Converter pin model with timing monitor and scoreboard
// ============================================================
`default_nettype none

module ad2s1210Tb import ad2s1210Pkg::*; ();

    localparam int FRAME_BITS   = 16;
    localparam int WAIT_LIMIT   = 2000;
    localparam int ROUNDS       = 5;
    localparam int CONVS        = 3;
    localparam int QUIET_CYCLES = 200;

    logic     sclk = 1'b0;
    logic     rst;
    logic     writeStrobe;
    logic     readStrobe;
    busAddr_t address;
    busData_t writeData;
    busData_t readData;
    logic     readValid;
    logic     miso;
    logic     spiClk;
    logic     csN;
    logic     sampleN;
    logic     resetN;
    logic     a0;
    logic     a1;
    logic     re0;
    logic     re1;

    logic [15:0]   lfsrState;
    // Divider in force for the current round
    int            curDiv;
    // Words the converter model holds for the running conversion
    resolverWord_t curPos;
    resolverWord_t curVel;
    resolverWord_t txWord;
    resolverWord_t posQ[$];
    resolverWord_t velQ[$];
    // Pin history from the previous cycle
    logic          prevSampleN;
    logic          prevCsN;
    logic          prevSpiClk;
    int            sampleFalls;
    int            sampleLow;
    int            settleCnt;
    logic          settleArmed;
    int            frameIdx;
    int            bitIdx;
    int            riseCnt;
    int            halfCnt;
    logic [1:0]    expAddr;

    ad2s1210Top #(
        .FRAME_BITS(FRAME_BITS)
    ) u_dut (
        .sclk        (sclk),
        .rst         (rst),
        .writeStrobe (writeStrobe),
        .readStrobe  (readStrobe),
        .address     (address),
        .writeData   (writeData),
        .readData    (readData),
        .readValid   (readValid),
        .miso        (miso),
        .spiClk      (spiClk),
        .csN         (csN),
        .sampleN     (sampleN),
        .resetN      (resetN),
        .a0          (a0),
        .a1          (a1),
        .re0         (re0),
        .re1         (re1)
    );

    always #5 sclk = ~sclk;

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    // Stepped once for every bit taken
    function automatic int takeBits(input int count);
        int   value;
        logic feedback;
        value = 0;
        for (int i = 0; i < count; i++) begin
            feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value     = (value << 1) | int'(feedback);
        end
        return value;
    endfunction

    task automatic reportFail(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        reportFail($sformatf("MISMATCH at %0t: %s got %0h expected %0h",
                             $time, name, got, expected));
    endtask

    // Converter model and pin timing monitor run once per cycle
    task automatic observePins();
        // New SAMPLE pulse draws fresh words for this conversion
        if (!sampleN && prevSampleN) begin
            assert (frameIdx == 2) else reportFail("conversion ended without two frames");
            sampleFalls++;
            sampleLow = 0;
            frameIdx  = 0;
            curPos    = resolverWord_t'(takeBits(16));
            curVel    = resolverWord_t'(takeBits(16));
            posQ.push_back(curPos);
            velQ.push_back(curVel);
        end
        if (!sampleN) begin
            sampleLow++;
        end
        if (sampleN && !prevSampleN) begin
            assert (sampleLow == SAMPLE_WIDTH)
                else reportMismatch("sampleN low cycles", sampleLow, SAMPLE_WIDTH);
            settleCnt   = 0;
            settleArmed = 1'b1;
        end else if (settleArmed) begin
            settleCnt++;
        end
        // MSB goes out on the csN fall
        if (!csN && prevCsN) begin
            if (frameIdx == 0) begin
                assert (settleArmed) else reportFail("csN fell before the SAMPLE pulse ended");
                assert (settleCnt == SETTLE_CYCLES)
                    else reportMismatch("settle cycles", settleCnt, SETTLE_CYCLES);
                settleArmed = 1'b0;
                expAddr     = 2'b00;
            end else begin
                assert (frameIdx == 1) else reportFail("more than two frames in one conversion");
                expAddr = 2'b10;
            end
            assert ({a1, a0} == expAddr)
                else reportMismatch("a1/a0", 32'({a1, a0}), 32'(expAddr));
            txWord  = ({a1, a0} == 2'b10) ? curVel : curPos;
            bitIdx  = FRAME_BITS - 1;
            miso    = txWord[bitIdx];
            riseCnt = 0;
            halfCnt = 0;
        end else if (!csN) begin
            halfCnt++;
            if (spiClk != prevSpiClk) begin
                assert (halfCnt == curDiv + 1)
                    else reportMismatch("spiClk half period", halfCnt, curDiv + 1);
                halfCnt = 0;
                if (spiClk) begin
                    riseCnt++;
                end else begin
                    // Next bit after each falling edge
                    if (bitIdx > 0) begin
                        bitIdx--;
                    end
                    miso = txWord[bitIdx];
                end
            end
        end else begin
            assert (spiClk) else reportFail("spiClk left idle high while csN was high");
        end
        if (csN && !prevCsN) begin
            assert (riseCnt == FRAME_BITS)
                else reportMismatch("spiClk rising edges", riseCnt, FRAME_BITS);
            frameIdx++;
        end
        prevSampleN = sampleN;
        prevCsN     = csN;
        prevSpiClk  = spiClk;
    endtask

    // Advance to 1 time unit after the next rising edge
    task automatic stepCycle();
        @(posedge sclk);
        #1;
        observePins();
    endtask

    task automatic busWrite(input busAddr_t addr, input busData_t data);
        writeStrobe = 1'b1;
        address     = addr;
        writeData   = data;
        stepCycle();
        writeStrobe = 1'b0;
    endtask

    task automatic busRead(input busAddr_t addr, output busData_t data);
        int waited;
        waited     = 0;
        readStrobe = 1'b1;
        address    = addr;
        stepCycle();
        readStrobe = 1'b0;
        while (!readValid) begin
            waited++;
            assert (waited < WAIT_LIMIT) else reportFail("readValid never followed a read");
            stepCycle();
        end
        data = readData;
    endtask

    task automatic checkRead(input busAddr_t addr, input busData_t expected, input string name);
        busData_t got;
        busRead(addr, got);
        assert (got == expected) else reportMismatch(name, got, expected);
    endtask

    // Control write followed by static pin checks and readback
    task automatic writeControl(input logic [3:0] ctrl);
        busWrite(ADDR_CTRL, {28'd0, ctrl});
        assert (resetN == ~ctrl[1]) else reportMismatch("resetN", 32'(resetN), 32'(~ctrl[1]));
        assert (re0 == ctrl[2]) else reportMismatch("re0", 32'(re0), 32'(ctrl[2]));
        assert (re1 == ctrl[3]) else reportMismatch("re1", 32'(re1), 32'(ctrl[3]));
        checkRead(ADDR_CTRL, {28'd0, ctrl}, "ADDR_CTRL");
    endtask

    // Compare the oldest recorded words with the sample registers
    task automatic checkSample();
        resolverWord_t pos;
        resolverWord_t vel;
        assert (posQ.size() > 0) else reportFail("sample stored without a SAMPLE pulse");
        pos = posQ.pop_front();
        vel = velQ.pop_front();
        checkRead(ADDR_POS, {16'd0, pos}, "ADDR_POS");
        checkRead(ADDR_VEL, {16'd0, vel}, "ADDR_VEL");
    endtask

    task automatic runConversions(input int count);
        busData_t lastCount;
        busData_t nowCount;
        int       waited;
        busRead(ADDR_COUNT, lastCount);
        for (int k = 0; k < count; k++) begin
            waited   = 0;
            nowCount = lastCount;
            while (nowCount == lastCount) begin
                waited++;
                assert (waited < WAIT_LIMIT) else reportFail("ADDR_COUNT did not change in time");
                busRead(ADDR_COUNT, nowCount);
            end
            assert (nowCount == lastCount + 1)
                else reportMismatch("ADDR_COUNT", nowCount, lastCount + 1);
            checkSample();
            lastCount = nowCount;
        end
    endtask

    // With enable clear the running conversion ends and no new one starts
    task automatic checkQuiet();
        busData_t count;
        busData_t later;
        int       waited;
        int       falls;
        waited = 0;
        busRead(ADDR_COUNT, count);
        while (count != busData_t'(sampleFalls)) begin
            waited++;
            assert (waited < WAIT_LIMIT) else reportFail("conversion did not finish after disable");
            busRead(ADDR_COUNT, count);
        end
        if (posQ.size() == 1) begin
            checkSample();
        end
        assert (posQ.size() == 0) else reportFail("recorded samples left unchecked");
        falls = sampleFalls;
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            stepCycle();
        end
        assert (sampleFalls == falls) else reportFail("SAMPLE pulse appeared while disabled");
        busRead(ADDR_COUNT, later);
        assert (later == count) else reportMismatch("ADDR_COUNT while disabled", later, count);
    endtask

    initial begin
        logic [1:0] resolution;
        logic       convReset;
        int         periodVal;
        int         value;
        lfsrState   = 16'd43;
        rst         = 1'b1;
        writeStrobe = 1'b0;
        readStrobe  = 1'b0;
        address     = '0;
        writeData   = '0;
        miso        = 1'b0;
        curDiv      = 0;
        prevSampleN = 1'b1;
        prevCsN     = 1'b1;
        prevSpiClk  = 1'b1;
        sampleFalls = 0;
        sampleLow   = 0;
        settleCnt   = 0;
        settleArmed = 1'b0;
        frameIdx    = 2;
        repeat (4) begin
            stepCycle();
        end
        rst = 1'b0;

        // All six registers clear after reset
        for (int a = 0; a < 6; a++) begin
            checkRead(busAddr_t'(a), '0, $sformatf("register %0d after reset", a));
        end

        // Random readback with the sequencer kept disabled
        for (int n = 0; n < 4; n++) begin
            resolution = 2'(takeBits(2));
            convReset  = 1'(takeBits(1));
            writeControl({resolution, convReset, 1'b0});
            value = takeBits(8);
            busWrite(ADDR_DIV, value);
            checkRead(ADDR_DIV, value, "ADDR_DIV");
            value = takeBits(16);
            busWrite(ADDR_PERIOD, value);
            checkRead(ADDR_PERIOD, value, "ADDR_PERIOD");
        end

        // Conversion rounds with a fresh divider, period and resolution
        for (int r = 0; r < ROUNDS; r++) begin
            curDiv     = takeBits(2);
            periodVal  = takeBits(6);
            resolution = 2'(takeBits(2));
            convReset  = 1'(takeBits(1));
            busWrite(ADDR_DIV, curDiv);
            busWrite(ADDR_PERIOD, periodVal);
            writeControl({resolution, convReset, 1'b1});
            runConversions(CONVS);
            writeControl({resolution, convReset, 1'b0});
            checkQuiet();
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/ad2s1210_assertions.sv ====
// ============================================================
// Concurrent pin-protocol assertions for the AD2S1210 top
// SAMPLE versus chip select, A0/A1 stability, read latency
// ============================================================
`default_nettype none

module ad2s1210Assertions (
    input logic sclk,
    input logic rst,
    input logic csN,
    input logic sampleN,
    input logic a0,
    input logic a1,
    input logic readStrobe,
    input logic readValid
);

    // No SAMPLE pulse inside a serial frame
    assert property (@(posedge sclk) disable iff (rst) !csN |-> sampleN)
        else $error("sampleN went low while csN was low");

    // Mode select held for the whole frame
    assert property (@(posedge sclk) disable iff (rst) !csN |-> $stable({a1, a0}))
        else $error("a0 or a1 changed while csN was low");

    // readValid only as the answer to a read strobe
    assert property (@(posedge sclk) disable iff (rst) readValid |-> $past(readStrobe))
        else $error("readValid rose without a read strobe one cycle earlier");

endmodule

bind ad2s1210Top ad2s1210Assertions u_assertions (
    .sclk       (sclk),
    .rst        (rst),
    .csN        (csN),
    .sampleN    (sampleN),
    .a0         (a0),
    .a1         (a1),
    .readStrobe (readStrobe),
    .readValid  (readValid)
);

`default_nettype wire

// ==== design/ad2s1210Top.sv ====
// ============================================================
// AD2S1210 controller top level
// Host register file plus conversion sequencer
// Static converter pins driven from the configuration
// ============================================================
`default_nettype none

module ad2s1210Top import ad2s1210Pkg::*; #(
    parameter int FRAME_BITS = 16
) (
    input  logic     sclk,
    input  logic     rst,
    // Host bus
    input  logic     writeStrobe,
    input  logic     readStrobe,
    input  busAddr_t address,
    input  busData_t writeData,
    output busData_t readData,
    output logic     readValid,
    // Converter pins
    input  logic     miso,
    output logic     spiClk,
    output logic     csN,
    output logic     sampleN,
    output logic     resetN,
    output logic     a0,
    output logic     a1,
    output logic     re0,
    output logic     re1
);

    resolverCfg_t    cfg;
    resolverSample_t sample;
    logic            sampleStrobe;
    // {A1, A0}
    logic [1:0]      addrSel;

    resolverRegs u_regs (
        .sclk         (sclk),
        .rst          (rst),
        .writeStrobe  (writeStrobe),
        .readStrobe   (readStrobe),
        .address      (address),
        .writeData    (writeData),
        .readData     (readData),
        .readValid    (readValid),
        .sample       (sample),
        .sampleStrobe (sampleStrobe),
        .cfg          (cfg)
    );

    resolverSequencer #(
        .FRAME_BITS(FRAME_BITS)
    ) u_sequencer (
        .sclk         (sclk),
        .rst          (rst),
        .cfg          (cfg),
        .miso         (miso),
        .spiClk       (spiClk),
        .csN          (csN),
        .sampleN      (sampleN),
        .addrSel      (addrSel),
        .sample       (sample),
        .sampleStrobe (sampleStrobe)
    );

    // Converter reset is active low
    assign resetN = ~cfg.convReset;
    assign re0    = cfg.resolution[0];
    assign re1    = cfg.resolution[1];
    assign a0     = addrSel[0];
    assign a1     = addrSel[1];

endmodule

`default_nettype wire

// ==== design/resolverSequencer.sv ====
// ============================================================
// Conversion sequencer for the AD2S1210
// Period timer, SAMPLE pulse, settle delay, A0/A1 select
// Position frame then velocity frame, sample hand-off
// ============================================================
`default_nettype none

module resolverSequencer import ad2s1210Pkg::*; #(
    parameter int FRAME_BITS = 16
) (
    input  logic            sclk,
    input  logic            rst,
    input  resolverCfg_t    cfg,
    input  logic            miso,
    output logic            spiClk,
    output logic            csN,
    output logic            sampleN,
    output logic [1:0]      addrSel,
    output resolverSample_t sample,
    output logic            sampleStrobe
);

    localparam int STEP_MAX = (SAMPLE_WIDTH > SETTLE_CYCLES) ? SAMPLE_WIDTH : SETTLE_CYCLES;
    localparam int STEP_W = $clog2(STEP_MAX) + 1;
    localparam logic [STEP_W-1:0] SAMPLE_LAST = STEP_W'(SAMPLE_WIDTH - 1);
    localparam logic [STEP_W-1:0] SETTLE_LAST = STEP_W'(SETTLE_CYCLES - 1);

    seqState_t         state;
    period_t           periodCnt;
    // Cycle counter for the SAMPLE and settle phases
    logic [STEP_W-1:0] stepCnt;
    logic [15:0]       sampleCount;
    resolverWord_t     posWord;
    resolverWord_t     velWord;
    resolverWord_t     rxWord;
    logic              frameStart;
    logic              frameDone;

    // Position frame starts at the end of settling
    // Velocity frame starts on the first READ_VEL cycle
    assign frameStart = (state == SEQ_SETTLE && stepCnt == SETTLE_LAST) ||
                        (state == SEQ_READ_VEL && stepCnt == '0);

    resolverSpiReader #(
        .FRAME_BITS(FRAME_BITS)
    ) u_spiReader (
        .sclk   (sclk),
        .rst    (rst),
        .start  (frameStart),
        .spiDiv (cfg.spiDiv),
        .miso   (miso),
        .spiClk (spiClk),
        .csN    (csN),
        .rxWord (rxWord),
        .done   (frameDone)
    );

    always_ff @(posedge sclk) begin
        if (rst) begin
            state        <= SEQ_IDLE;
            periodCnt    <= '0;
            stepCnt      <= '0;
            sampleN      <= 1'b1;
            addrSel      <= 2'b00;
            sampleCount  <= '0;
            sampleStrobe <= 1'b0;
        end else begin
            sampleStrobe <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (cfg.enable) begin
                        periodCnt <= cfg.period;
                        state     <= SEQ_WAIT_PERIOD;
                    end
                end
                SEQ_WAIT_PERIOD: begin
                    // Disabled before SAMPLE, nothing to finish
                    if (!cfg.enable) begin
                        state <= SEQ_IDLE;
                    end else if (periodCnt == '0) begin
                        sampleN <= 1'b0;
                        stepCnt <= '0;
                        state   <= SEQ_SAMPLE;
                    end else begin
                        periodCnt <= periodCnt - 1'b1;
                    end
                end
                SEQ_SAMPLE: begin
                    if (stepCnt == SAMPLE_LAST) begin
                        sampleN <= 1'b1;
                        stepCnt <= '0;
                        state   <= SEQ_SETTLE;
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                    end
                end
                SEQ_SETTLE: begin
                    if (frameStart) begin
                        state <= SEQ_READ_POS;
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                    end
                end
                SEQ_READ_POS: begin
                    // Switch to velocity while csN is back high
                    if (frameDone) begin
                        addrSel <= 2'b10;
                        stepCnt <= '0;
                        state   <= SEQ_READ_VEL;
                    end
                end
                SEQ_READ_VEL: begin
                    if (frameStart) begin
                        stepCnt <= 1;
                    end else if (frameDone) begin
                        state <= SEQ_STORE;
                    end
                end
                SEQ_STORE: begin
                    sampleCount  <= sampleCount + 1'b1;
                    sampleStrobe <= 1'b1;
                    addrSel      <= 2'b00;
                    // Period restarts from the end of this conversion
                    periodCnt    <= cfg.period;
                    state        <= cfg.enable ? SEQ_WAIT_PERIOD : SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Data words from the two frames
    always_ff @(posedge sclk) begin
        if (state == SEQ_READ_POS && frameDone) begin
            posWord <= rxWord;
        end
        if (state == SEQ_READ_VEL && frameDone) begin
            velWord <= rxWord;
        end
    end

    // Stable while sampleStrobe is high
    always_comb begin
        sample.position    = posWord;
        sample.velocity    = velWord;
        sample.sampleCount = sampleCount;
    end

endmodule

`default_nettype wire

// ==== design/resolverSpiReader.sv ====
// ============================================================
// Serial read master for the AD2S1210 data port
// Divided spiClk from a half-period counter
// MSB-first shift on rising edges, done pulse per frame
// ============================================================
`default_nettype none

module resolverSpiReader import ad2s1210Pkg::*; #(
    parameter int FRAME_BITS = 16
) (
    input  logic          sclk,
    input  logic          rst,
    input  logic          start,
    input  spiDiv_t       spiDiv,
    input  logic          miso,
    output logic          spiClk,
    output logic          csN,
    output resolverWord_t rxWord,
    output logic          done
);

    localparam int BIT_W = (FRAME_BITS > 1) ? $clog2(FRAME_BITS) : 1;
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(FRAME_BITS - 1);
    localparam int WORD_W = $bits(resolverWord_t);

    spiState_t        state;
    // Cycles spent in the current half period
    spiDiv_t          halfCnt;
    // Index of the bit in flight
    logic [BIT_W-1:0] bitCnt;
    resolverWord_t    shiftReg;
    // Current half period is over
    logic             halfEnd;

    // Compare with >= so a divider lowered mid-frame cannot stall the count
    assign halfEnd = (halfCnt >= spiDiv);

    always_ff @(posedge sclk) begin
        if (rst) begin
            state   <= SPI_IDLE;
            spiClk  <= 1'b1;
            csN     <= 1'b1;
            halfCnt <= '0;
            bitCnt  <= '0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    // csN and the first spiClk fall share one edge
                    // The converter puts its MSB out on the csN fall
                    if (start) begin
                        csN     <= 1'b0;
                        spiClk  <= 1'b0;
                        halfCnt <= '0;
                        bitCnt  <= '0;
                        state   <= SPI_LOW_HALF;
                    end
                end
                SPI_LOW_HALF: begin
                    if (halfEnd) begin
                        spiClk  <= 1'b1;
                        halfCnt <= '0;
                        // Last rising edge ends the frame
                        if (bitCnt == LAST_BIT) begin
                            state <= SPI_DONE;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                            state  <= SPI_HIGH_HALF;
                        end
                    end else begin
                        halfCnt <= halfCnt + 1'b1;
                    end
                end
                SPI_HIGH_HALF: begin
                    if (halfEnd) begin
                        spiClk  <= 1'b0;
                        halfCnt <= '0;
                        state   <= SPI_LOW_HALF;
                    end else begin
                        halfCnt <= halfCnt + 1'b1;
                    end
                end
                SPI_DONE: begin
                    // csN rises one cycle after the last rising edge
                    csN   <= 1'b1;
                    state <= SPI_IDLE;
                end
                default: begin
                    state <= SPI_IDLE;
                end
            endcase
        end
    end

    // Receive shift register, MSB first
    always_ff @(posedge sclk) begin
        if (state == SPI_IDLE && start) begin
            shiftReg <= '0;
        end else if (state == SPI_LOW_HALF && halfEnd) begin
            // Sample miso on the rising spiClk edge
            shiftReg <= {shiftReg[WORD_W-2:0], miso};
        end
    end

    // Word holds from done until the next start clears it
    assign rxWord = shiftReg;
    assign done   = (state == SPI_DONE);

endmodule

`default_nettype wire

// ==== design/resolverRegs.sv ====
// ============================================================
// Host register file for the resolver controller
// Holds enable, reset, resolution, divider and period
// Latches finished samples, registered read path
// ============================================================
`default_nettype none

module resolverRegs import ad2s1210Pkg::*; (
    input  logic            sclk,
    input  logic            rst,
    input  logic            writeStrobe,
    input  logic            readStrobe,
    input  busAddr_t        address,
    input  busData_t        writeData,
    output busData_t        readData,
    output logic            readValid,
    input  resolverSample_t sample,
    input  logic            sampleStrobe,
    output resolverCfg_t    cfg
);

    // Last sample handed over by the sequencer
    resolverSample_t sampleReg;
    // Combinational read selection
    busData_t        readMux;

    // Configuration writes
    always_ff @(posedge sclk) begin
        if (rst) begin
            cfg <= '0;
        end else if (writeStrobe) begin
            case (address)
                ADDR_CTRL: begin
                    cfg.enable     <= writeData[0];
                    cfg.convReset  <= writeData[1];
                    cfg.resolution <= writeData[3:2];
                end
                ADDR_DIV: begin
                    cfg.spiDiv <= writeData[7:0];
                end
                ADDR_PERIOD: begin
                    cfg.period <= writeData[15:0];
                end
                // Sample registers are read only
                default: begin
                end
            endcase
        end
    end

    // Capture completed conversions
    // Cleared so that the sample registers read zero after reset
    always_ff @(posedge sclk) begin
        if (rst) begin
            sampleReg <= '0;
        end else if (sampleStrobe) begin
            sampleReg <= sample;
        end
    end

    // Read selection, unused addresses give zero
    always_comb begin
        readMux = '0;
        case (address)
            ADDR_CTRL:   readMux = {28'd0, cfg.resolution, cfg.convReset, cfg.enable};
            ADDR_DIV:    readMux = {24'd0, cfg.spiDiv};
            ADDR_PERIOD: readMux = {16'd0, cfg.period};
            ADDR_POS:    readMux = {16'd0, sampleReg.position};
            ADDR_VEL:    readMux = {16'd0, sampleReg.velocity};
            ADDR_COUNT:  readMux = {16'd0, sampleReg.sampleCount};
            default:     readMux = '0;
        endcase
    end

    // Fixed one-cycle read latency
    always_ff @(posedge sclk) begin
        if (rst) begin
            readData  <= '0;
            readValid <= 1'b0;
        end else begin
            readValid <= readStrobe;
            if (readStrobe) begin
                readData <= readMux;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ad2s1210Pkg.sv ====
// ============================================================
// Shared definitions for the AD2S1210 resolver controller
// Width typedefs, config and sample structs, FSM state enums
// Host register map and converter pin timing constants
// ============================================================
`default_nettype none

package ad2s1210Pkg;

    // Host bus widths
    typedef logic [3:0]  busAddr_t;
    typedef logic [31:0] busData_t;

    // One converter data word
    typedef logic [15:0] resolverWord_t;
    // Half period of spiClk is spiDiv + 1 system cycles
    typedef logic [7:0]  spiDiv_t;
    // Idle time between conversions, in system cycles
    typedef logic [15:0] period_t;

    // Configuration held by the register file
    typedef struct packed {
        logic       enable;
        // Set holds the converter's reset pin low
        logic       convReset;
        // Drives RE1/RE0
        logic [1:0] resolution;
        spiDiv_t    spiDiv;
        period_t    period;
    } resolverCfg_t;

    // Result of one finished conversion
    typedef struct packed {
        resolverWord_t position;
        resolverWord_t velocity;
        logic [15:0]   sampleCount;
    } resolverSample_t;

    // Conversion sequencer states
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_WAIT_PERIOD,
        SEQ_SAMPLE,
        SEQ_SETTLE,
        SEQ_READ_POS,
        SEQ_READ_VEL,
        SEQ_STORE
    } seqState_t;

    // Serial reader states
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_LOW_HALF,
        SPI_HIGH_HALF,
        SPI_DONE
    } spiState_t;

    // Register map, word addresses
    localparam busAddr_t ADDR_CTRL   = 4'd0;
    localparam busAddr_t ADDR_DIV    = 4'd1;
    localparam busAddr_t ADDR_PERIOD = 4'd2;
    localparam busAddr_t ADDR_POS    = 4'd3;
    localparam busAddr_t ADDR_VEL    = 4'd4;
    localparam busAddr_t ADDR_COUNT  = 4'd5;

    // Cycles SAMPLE is held low
    localparam int SAMPLE_WIDTH  = 4;
    // Cycles from SAMPLE rising to the first chip select
    localparam int SETTLE_CYCLES = 4;

endpackage

`default_nettype wire
